// File: vlog.f
logic/datapath_pkg.sv
logic/isa_pkg.sv
logic/operand_stage.sv
logic/shift_unit.sv
logic/alu.sv
logic/execute_stage.sv
logic/memory_stage.sv
logic/arm_core_top.sv
bench/tb_arm_core.sv

// File: run_verilator.sh
#!/usr/bin/env bash
# Build and run the testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module tb_arm_core -Mdir obj_dir -f vlog.f
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

output="$(./obj_dir/Vtb_arm_core 2>&1)"
status=$?
echo "$output"

if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if echo "$output" | grep -Fqx "PASS: all tests"; then
  exit 0
fi
echo "Pass message not found"
exit 1

// File: bench/tb_arm_core.sv
`default_nettype none

module tb_arm_core;

  localparam int CLK_PERIOD = 100;
  localparam int SEED = 35796;
  localparam int DMEM_WORDS = 64;
  localparam int N_DP = 300;
  localparam int N_CHAIN = 60;
  localparam int N_LS = 150;
  localparam int N_BR = 40;
  localparam int N_TOTAL = 16 + DMEM_WORDS + N_DP + N_CHAIN + 2 * N_LS + 5 * N_BR;
  localparam int WATCHDOG_TIME = (3 * N_TOTAL + 200) * CLK_PERIOD;

  // Expected DUT activity for one clock cycle
  typedef struct packed {
    logic        wb;
    logic [3:0]  addr;
    logic [31:0] data;
    logic        br;
    logic [31:0] off;
    logic        stall;
    logic        fl;
    logic [3:0]  flags;
  } event_t;

  logic clk_i;
  logic reset_i;
  logic [datapath_pkg::WORD_W-1:0] instr_i;
  logic instr_valid_i;
  logic stall_o;
  logic branch_taken_o;
  logic [datapath_pkg::WORD_W-1:0] branch_offset_o;
  logic [datapath_pkg::FLAG_W-1:0] flags_o;
  logic wb_en_o;
  logic [datapath_pkg::REG_AW-1:0] wb_addr_o;
  logic [datapath_pkg::WORD_W-1:0] wb_data_o;

  // Shadow architectural state
  logic [31:0] shadow_regs [16];
  logic [31:0] shadow_mem [DMEM_WORDS];
  logic [3:0] flags_m = '0;

  // Pipeline timing of the previous instruction
  int squash_edge = -1;
  int last_exec = -1;
  logic load_fired = 1'b0;
  logic [3:0] load_rd = '0;

  event_t sched [int];
  int cyc = 0;
  logic exp_wb = 1'b0;
  logic [3:0] exp_addr = '0;
  logic [31:0] exp_data = '0;
  logic exp_br = 1'b0;
  logic [31:0] exp_off = '0;
  logic exp_stall = 1'b0;
  logic [3:0] exp_flags = '0;

  arm_core_top #(
      .DMEM_WORDS (DMEM_WORDS)
  ) DUT (
      .clk_i           (clk_i)
    , .reset_i         (reset_i)
    , .instr_i         (instr_i)
    , .instr_valid_i   (instr_valid_i)
    , .stall_o         (stall_o)
    , .branch_taken_o  (branch_taken_o)
    , .branch_offset_o (branch_offset_o)
    , .flags_o         (flags_o)
    , .wb_en_o         (wb_en_o)
    , .wb_addr_o       (wb_addr_o)
    , .wb_data_o       (wb_data_o)
  );

  initial begin
    clk_i = 1'b0;
    forever #(CLK_PERIOD / 2) clk_i = ~clk_i;
  end

  always @(posedge clk_i) begin
    cyc <= cyc + 1;
  end

  task automatic stop_on_error(input string msg);
    $display("** Error: %0t: %s", $time, msg);
    $display("FAIL: see errors above");
    $fatal(1, "stopped at first mismatch");
  endtask

  // ********************
  // Checking
  // ********************

  // Load this cycle's expectations between clock edges
  always @(negedge clk_i) begin
    event_t ev;
    ev = '0;
    if (sched.exists(cyc)) begin
      ev = sched[cyc];
      sched.delete(cyc);
    end
    exp_wb    = ev.wb;
    exp_addr  = ev.addr;
    exp_data  = ev.data;
    exp_br    = ev.br;
    exp_off   = ev.off;
    exp_stall = ev.stall;
    if (ev.fl) begin
      exp_flags = ev.flags;
    end
  end

  a_wb_en: assert property (@(posedge clk_i) disable iff (reset_i) wb_en_o == exp_wb)
    else stop_on_error("write-back enable does not match the model");
  a_wb_data: assert property (@(posedge clk_i) disable iff (reset_i)
    exp_wb |-> (wb_addr_o == exp_addr && wb_data_o == exp_data))
    else stop_on_error($sformatf("write-back mismatch, expected r%0d = %h", exp_addr, exp_data));
  a_flags: assert property (@(posedge clk_i) disable iff (reset_i) flags_o == exp_flags)
    else stop_on_error($sformatf("flags mismatch, expected %b", exp_flags));
  a_stall: assert property (@(posedge clk_i) disable iff (reset_i) stall_o == exp_stall)
    else stop_on_error("stall does not match the load-use model");
  a_stall_len: assert property (@(posedge clk_i) disable iff (reset_i) stall_o |=> !stall_o)
    else stop_on_error("stall lasted more than one cycle");
  a_branch: assert property (@(posedge clk_i) disable iff (reset_i) branch_taken_o == exp_br)
    else stop_on_error("branch pulse does not match the model");
  a_offset: assert property (@(posedge clk_i) disable iff (reset_i)
    exp_br |-> branch_offset_o == exp_off)
    else stop_on_error($sformatf("branch offset mismatch, expected %h", exp_off));

  // ********************
  // Reference model
  // ********************
  function automatic logic cond_ok(input logic [3:0] cond, input logic [3:0] f);
    logic n;
    logic z;
    logic c;
    logic v;
    n = f[datapath_pkg::FLAG_N];
    z = f[datapath_pkg::FLAG_Z];
    c = f[datapath_pkg::FLAG_C];
    v = f[datapath_pkg::FLAG_V];
    case (cond)
      4'd0:    return z;
      4'd1:    return !z;
      4'd2:    return c;
      4'd3:    return !c;
      4'd4:    return n;
      4'd5:    return !n;
      4'd6:    return v;
      4'd7:    return !v;
      4'd8:    return c && !z;
      4'd9:    return !c || z;
      4'd10:   return n == v;
      4'd11:   return n != v;
      4'd12:   return !z && (n == v);
      4'd13:   return z || (n != v);
      4'd14:   return 1'b1;
      default: return 1'b0;
    endcase
  endfunction

  function automatic void exec_dp(input logic [31:0] w, output logic [31:0] res,
                                  output logic [3:0] f_out);
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] m;
    logic [31:0] x;
    logic [31:0] y;
    logic [32:0] s;
    logic sc;
    logic cin;
    logic arith;
    int amt;
    int rot;
    a  = shadow_regs[w[19:16]];
    sc = flags_m[datapath_pkg::FLAG_C];
    if (w[25]) begin
      rot = 2 * int'(w[11:8]);
      m   = {24'b0, w[7:0]};
      b   = (m >> rot) | (m << (32 - rot));
      if (rot != 0) sc = b[31];
    end else begin
      m   = shadow_regs[w[3:0]];
      amt = int'(w[11:7]);
      b   = m;
      // Zero amount means no shift for every type
      if (amt != 0) begin
        case (w[6:5])
          2'd0: begin
            b  = m << amt;
            sc = m[32 - amt];
          end
          2'd1: begin
            b  = m >> amt;
            sc = m[amt - 1];
          end
          2'd2: begin
            b  = $signed(m) >>> amt;
            sc = m[amt - 1];
          end
          default: begin
            b  = (m >> amt) | (m << (32 - amt));
            sc = b[31];
          end
        endcase
      end
    end
    x     = a;
    y     = b;
    cin   = 1'b0;
    arith = 1'b1;
    case (w[24:21])
      4'd2, 4'd10: begin
        y   = ~b;
        cin = 1'b1;
      end
      4'd3: begin
        x   = b;
        y   = ~a;
        cin = 1'b1;
      end
      4'd4, 4'd11: cin = 1'b0;
      4'd5: cin = flags_m[datapath_pkg::FLAG_C];
      4'd6: begin
        y   = ~b;
        cin = flags_m[datapath_pkg::FLAG_C];
      end
      4'd7: begin
        x   = b;
        y   = ~a;
        cin = flags_m[datapath_pkg::FLAG_C];
      end
      default: arith = 1'b0;
    endcase
    s = {1'b0, x} + {1'b0, y} + {32'b0, cin};
    case (w[24:21])
      4'd0, 4'd8:  res = a & b;
      4'd1, 4'd9:  res = a ^ b;
      4'd12:       res = a | b;
      4'd13:       res = b;
      4'd14:       res = a & ~b;
      4'd15:       res = ~b;
      default:     res = s[31:0];
    endcase
    f_out[datapath_pkg::FLAG_N] = res[31];
    f_out[datapath_pkg::FLAG_Z] = (res == 32'd0);
    f_out[datapath_pkg::FLAG_C] = arith ? s[32] : sc;
    f_out[datapath_pkg::FLAG_V] = arith ? ((x[31] == y[31]) && (s[31] != x[31]))
                                        : flags_m[datapath_pkg::FLAG_V];
  endfunction

  function automatic event_t entry_at(input int c);
    if (sched.exists(c)) return sched[c];
    return '0;
  endfunction

  function automatic void expect_write(input int c, input logic [3:0] rd, input logic [31:0] v);
    event_t ev;
    ev      = entry_at(c);
    ev.wb   = 1'b1;
    ev.addr = rd;
    ev.data = v;
    sched[c] = ev;
    shadow_regs[rd] = v;
  endfunction

  // Apply one instruction accepted at clock edge a
  function automatic void model_step(input logic [31:0] w, input int a);
    logic [2:0] cls;
    logic is_dp;
    logic is_ls;
    logic is_st;
    logic reads_rn;
    logic reads_b;
    logic squashed;
    logic stalled;
    logic [3:0] rn;
    logic [3:0] rd;
    logic [3:0] rb;
    logic [3:0] f_new;
    logic [31:0] res;
    logic [31:0] addr;
    int idx;
    int e;
    event_t ev;
    cls   = w[27:25];
    is_dp = (cls == 3'b000) || (cls == 3'b001);
    is_ls = (cls == 3'b010);
    is_st = is_ls && !w[20];
    rn    = w[19:16];
    rd    = w[15:12];
    rb    = is_st ? rd : w[3:0];
    // MOV and MVN take only the second operand
    reads_rn = is_ls || (is_dp && w[24:21] != 4'd13 && w[24:21] != 4'd15);
    reads_b  = (cls == 3'b000) || is_st;
    squashed = (a == squash_edge);
    stalled  = !squashed && load_fired && (a == last_exec)
               && ((reads_rn && rn == load_rd) || (reads_b && rb == load_rd));
    e = a + 1 + (stalled ? 1 : 0);
    if (stalled) begin
      ev = entry_at(a);
      ev.stall = 1'b1;
      sched[a] = ev;
    end
    load_fired = 1'b0;
    last_exec  = e;
    if (!squashed && cond_ok(w[31:28], flags_m)) begin
      if (is_dp) begin
        exec_dp(w, res, f_new);
        if (w[20]) flags_m = f_new;
        if (w[24:23] != 2'b10) expect_write(e + 1, rd, res);
      end else if (is_ls) begin
        addr = w[23] ? shadow_regs[rn] + {20'b0, w[11:0]} : shadow_regs[rn] - {20'b0, w[11:0]};
        idx  = int'((addr >> 2) % DMEM_WORDS);
        if (is_st) begin
          shadow_mem[idx] = shadow_regs[rd];
        end else begin
          expect_write(e + 1, rd, shadow_mem[idx]);
          load_fired = 1'b1;
          load_rd    = rd;
        end
      end else if (cls == 3'b101) begin
        ev        = entry_at(e);
        ev.br     = 1'b1;
        ev.off    = {{6{w[23]}}, w[23:0], 2'b00};
        sched[e]  = ev;
        squash_edge = e;
      end
    end
    ev = entry_at(e);
    ev.fl    = 1'b1;
    ev.flags = flags_m;
    sched[e] = ev;
  endfunction

  // ********************
  // Stimulus
  // ********************
  task automatic issue(input logic [31:0] w);
    logic held;
    int a;
    instr_i       <= w;
    instr_valid_i <= 1'b1;
    do begin
      @(negedge clk_i);
      held = stall_o;
      a    = cyc + 1;
      @(posedge clk_i);
    end while (held);
    model_step(w, a);
  endtask

  task automatic idle(input int n);
    instr_valid_i <= 1'b0;
    repeat (n) @(posedge clk_i);
  endtask

  function automatic logic [3:0] pick_cond();
    if ($urandom_range(0, 1) == 0) return 4'hE;
    return 4'($urandom_range(0, 14));
  endfunction

  function automatic logic [31:0] rand_dp(input logic [3:0] rn, input logic [3:0] rm,
                                          input logic any_cond);
    logic [3:0] cond;
    logic [3:0] op;
    logic s;
    logic [3:0] rd;
    cond = any_cond ? pick_cond() : 4'hE;
    op   = 4'($urandom);
    s    = 1'($urandom);
    // R13 stays the load/store base
    rd   = 4'($urandom_range(0, 12));
    if ($urandom_range(0, 1) == 0) begin
      return {cond, 3'b000, op, s, rn, rd, 5'($urandom), 2'($urandom), 1'b0, rm};
    end
    return {cond, 3'b001, op, s, rn, rd, 4'($urandom), 8'($urandom)};
  endfunction

  // Single transfer with pre-indexed immediate offset from R13
  function automatic logic [31:0] ldst(input logic [3:0] cond, input logic l, input logic u,
                                       input logic [3:0] rd, input logic [11:0] off);
    return {cond, 3'b010, 1'b1, u, 1'b0, 1'b0, l, 4'd13, rd, off};
  endfunction

  function automatic logic [11:0] rand_off();
    return {2'b00, 8'($urandom), 2'b00};
  endfunction

  initial begin
    #(WATCHDOG_TIME);
    $display("Timeout: the run did not finish in time");
    $display("FAIL: see errors above");
    $fatal(1, "watchdog expired");
  end

  initial begin
    logic [31:0] w;
    logic [3:0] prev1;
    logic [3:0] prev2;
    logic [3:0] ld;
    int i;
    void'($urandom(SEED));
    reset_i       = 1'b1;
    instr_i       = '0;
    instr_valid_i = 1'b0;
    repeat (10) @(posedge clk_i);
    reset_i <= 1'b0;
    idle(2);

    // Register setup with MOV immediate
    for (i = 0; i < 16; i++) begin
      if (i == 13) begin
        issue({4'hE, 3'b001, 4'd13, 1'b0, 4'd0, 4'd13, 4'd0, 8'h10});
      end else begin
        issue({4'hE, 3'b001, 4'd13, 1'b0, 4'd0, 4'(i), 4'($urandom), 8'($urandom)});
      end
    end
    for (i = 0; i < DMEM_WORDS; i++) begin
      issue(ldst(4'hE, 1'b0, 1'b1, 4'(i % 16), 12'(i * 4)));
    end

    for (i = 0; i < N_DP; i++) begin
      issue(rand_dp(4'($urandom), 4'($urandom), 1'b1));
    end

    // Each link reads the two results before it
    prev1 = 4'd0;
    prev2 = 4'd1;
    for (i = 0; i < N_CHAIN; i++) begin
      w = rand_dp(prev1, prev2, 1'b0);
      issue(w);
      prev2 = prev1;
      prev1 = w[15:12];
    end

    for (i = 0; i < N_LS; i++) begin
      ld = 4'($urandom_range(0, 12));
      case ($urandom_range(0, 2))
        0: issue(ldst(pick_cond(), 1'b0, 1'($urandom), 4'($urandom), rand_off()));
        1: begin
          issue(ldst(pick_cond(), 1'b1, 1'($urandom), ld, rand_off()));
          issue(rand_dp(ld, ld, 1'b0));
        end
        default: begin
          issue(ldst(4'hE, 1'b1, 1'($urandom), ld, rand_off()));
          issue(ldst(4'hE, 1'b0, 1'($urandom), ld, rand_off()));
        end
      endcase
    end

    // Compare, branch, then the slot that a taken branch squashes
    for (i = 0; i < N_BR; i++) begin
      issue({4'hE, 3'b000, 4'd10, 1'b1, 4'($urandom), 4'd0,
             5'($urandom), 2'($urandom), 1'b0, 4'($urandom)});
      issue({4'($urandom_range(0, 14)), 3'b101, 1'b0, 24'($urandom)});
      issue(rand_dp(4'($urandom), 4'($urandom), 1'b0));
      issue(rand_dp(4'($urandom), 4'($urandom), 1'b1));
      if ($urandom_range(0, 3) == 0) idle(1);
    end

    idle(12);
    if (sched.size() == 0) begin
      $display("PASS: all tests");
      $finish;
    end else begin
      $display("Expected pipeline events never happened: %0d left", sched.size());
      $display("FAIL: see errors above");
      $fatal(1, "pipeline did not drain");
    end
  end

endmodule

`default_nettype wire

// File: logic/arm_core_top.sv
`default_nettype none

module arm_core_top #(
    parameter int DMEM_WORDS = 64
) (
    input  logic clk_i
  , input  logic reset_i
  , input  logic [datapath_pkg::WORD_W-1:0] instr_i
  , input  logic instr_valid_i
  , output logic stall_o
  , output logic branch_taken_o
  , output logic [datapath_pkg::WORD_W-1:0] branch_offset_o
  , output logic [datapath_pkg::FLAG_W-1:0] flags_o
  , output logic wb_en_o
  , output logic [datapath_pkg::REG_AW-1:0] wb_addr_o
  , output logic [datapath_pkg::WORD_W-1:0] wb_data_o
);

  logic [datapath_pkg::WORD_W-1:0] op_inst;
  logic op_valid;
  logic [datapath_pkg::WORD_W-1:0] rs_data_a;
  logic [datapath_pkg::WORD_W-1:0] rs_data_b;
  logic squash;
  logic ex_valid;
  logic [datapath_pkg::WORD_W-1:0] ex_inst;
  logic [datapath_pkg::WORD_W-1:0] ex_result;
  logic [datapath_pkg::WORD_W-1:0] ex_store_data;
  logic ex_write;

  operand_stage u_operand (
      .clk_i         (clk_i)
    , .reset_i       (reset_i)
    , .instr_i       (instr_i)
    , .instr_valid_i (instr_valid_i)
    , .hold_i        (stall_o)
    , .squash_i      (squash)
    , .wb_en_i       (wb_en_o)
    , .wb_addr_i     (wb_addr_o)
    , .wb_data_i     (wb_data_o)
    , .op_inst_o     (op_inst)
    , .op_valid_o    (op_valid)
    , .rs_data_a_o   (rs_data_a)
    , .rs_data_b_o   (rs_data_b)
  );

  execute_stage u_execute (
      .clk_i           (clk_i)
    , .reset_i         (reset_i)
    , .op_inst_i       (op_inst)
    , .op_valid_i      (op_valid)
    , .rs_data_a_i     (rs_data_a)
    , .rs_data_b_i     (rs_data_b)
    , .wb_en_i         (wb_en_o)
    , .wb_addr_i       (wb_addr_o)
    , .wb_data_i       (wb_data_o)
    , .stall_o         (stall_o)
    , .squash_o        (squash)
    , .branch_taken_o  (branch_taken_o)
    , .branch_offset_o (branch_offset_o)
    , .flags_o         (flags_o)
    , .ex_valid_o      (ex_valid)
    , .ex_inst_o       (ex_inst)
    , .ex_result_o     (ex_result)
    , .ex_store_data_o (ex_store_data)
    , .ex_write_o      (ex_write)
  );

  memory_stage #(
      .DMEM_WORDS (DMEM_WORDS)
  ) u_memory (
      .clk_i           (clk_i)
    , .reset_i         (reset_i)
    , .ex_valid_i      (ex_valid)
    , .ex_inst_i       (ex_inst)
    , .ex_result_i     (ex_result)
    , .ex_store_data_i (ex_store_data)
    , .ex_write_i      (ex_write)
    , .wb_en_o         (wb_en_o)
    , .wb_addr_o       (wb_addr_o)
    , .wb_data_o       (wb_data_o)
  );

endmodule

`default_nettype wire

// File: logic/memory_stage.sv
`default_nettype none

module memory_stage #(
    parameter int DMEM_WORDS = 64
) (
    input  logic clk_i
  , input  logic reset_i
  , input  logic ex_valid_i
  , input  logic [datapath_pkg::WORD_W-1:0] ex_inst_i
  , input  logic [datapath_pkg::WORD_W-1:0] ex_result_i
  , input  logic [datapath_pkg::WORD_W-1:0] ex_store_data_i
  , input  logic ex_write_i
  , output logic wb_en_o
  , output logic [datapath_pkg::REG_AW-1:0] wb_addr_o
  , output logic [datapath_pkg::WORD_W-1:0] wb_data_o
);

  localparam int AW = $clog2(DMEM_WORDS);

  logic [datapath_pkg::WORD_W-1:0] mem [DMEM_WORDS];
  isa_pkg::inst_u ex;
  logic is_ldst;
  logic [AW-1:0] idx;

  assign ex      = ex_inst_i;
  assign is_ldst = (ex.ls.cls == isa_pkg::CLS_LDST);

  // Word index from the byte address
  assign idx = ex_result_i[AW+1:2];

  always_ff @(posedge clk_i) begin
    if (ex_valid_i && is_ldst && !ex.ls.l) begin
      mem[idx] <= ex_store_data_i;
    end
  end

  // ********************
  // Write-back port
  // ********************
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      wb_en_o <= 1'b0;
    end else begin
      wb_en_o <= ex_valid_i && ex_write_i;
    end
  end

  always_ff @(posedge clk_i) begin
    wb_addr_o <= ex.ls.rd;
    wb_data_o <= (is_ldst && ex.ls.l) ? mem[idx] : ex_result_i;
  end

  // Addresses come from the execute adder
  a_word_aligned: assert property (
    @(posedge clk_i) disable iff (reset_i)
    (ex_valid_i && is_ldst) |-> (ex_result_i[1:0] == 2'b00)
  );

endmodule

`default_nettype wire

// File: logic/execute_stage.sv
`default_nettype none

module execute_stage (
    input  logic clk_i
  , input  logic reset_i
  , input  logic [datapath_pkg::WORD_W-1:0] op_inst_i
  , input  logic op_valid_i
  , input  logic [datapath_pkg::WORD_W-1:0] rs_data_a_i
  , input  logic [datapath_pkg::WORD_W-1:0] rs_data_b_i
  , input  logic wb_en_i
  , input  logic [datapath_pkg::REG_AW-1:0] wb_addr_i
  , input  logic [datapath_pkg::WORD_W-1:0] wb_data_i
  , output logic stall_o
  , output logic squash_o
  , output logic branch_taken_o
  , output logic [datapath_pkg::WORD_W-1:0] branch_offset_o
  , output logic [datapath_pkg::FLAG_W-1:0] flags_o
  , output logic ex_valid_o
  , output logic [datapath_pkg::WORD_W-1:0] ex_inst_o
  , output logic [datapath_pkg::WORD_W-1:0] ex_result_o
  , output logic [datapath_pkg::WORD_W-1:0] ex_store_data_o
  , output logic ex_write_o
);

  localparam int W = datapath_pkg::WORD_W;
  localparam int AW = datapath_pkg::REG_AW;

  isa_pkg::inst_u op;
  isa_pkg::inst_u ex;
  logic is_dp, is_ldst, is_load, is_store, is_br;
  logic uses_rn, uses_b;
  logic [AW-1:0] addr_b;
  logic ex_fwd_ok;
  logic [W-1:0] opa, opb, op2;
  logic [W-1:0] shifted, imm;
  logic shift_carry, imm_carry;
  isa_pkg::alu_op_e alu_op;
  logic [W-1:0] alu_result;
  logic cond_met, fire, write;

  assign op = op_inst_i;
  assign ex = ex_inst_o;

  // ********************
  // Decode
  // ********************
  assign is_dp    = (op.dp.cls == isa_pkg::CLS_DP_REG) || (op.dp.cls == isa_pkg::CLS_DP_IMM);
  assign is_ldst  = (op.ls.cls == isa_pkg::CLS_LDST);
  assign is_load  = is_ldst && op.ls.l;
  assign is_store = is_ldst && !op.ls.l;
  assign is_br    = (op.br.cls == isa_pkg::CLS_BRANCH);
  assign addr_b   = is_store ? op.ls.rd : op.dp.op2.sh.rm;

  // MOV and MVN ignore Rn
  assign uses_rn = is_ldst || (is_dp && op.dp.opcode != isa_pkg::OP_MOV
                               && op.dp.opcode != isa_pkg::OP_MVN);
  assign uses_b  = (op.dp.cls == isa_pkg::CLS_DP_REG) || is_store;

  // ********************
  // Forwarding and load-use stall
  // ********************

  // Load data is not ready until the write-back port
  assign ex_fwd_ok = ex_valid_o && ex_write_o
                     && !(ex.ls.cls == isa_pkg::CLS_LDST && ex.ls.l);

  function automatic logic [W-1:0] fwd(input logic [AW-1:0] addr, input logic [W-1:0] rf);
    if (ex_fwd_ok && ex.dp.rd == addr) begin
      return ex_result_o;
    end
    if (wb_en_i && wb_addr_i == addr) begin
      return wb_data_i;
    end
    return rf;
  endfunction

  always_comb begin
    opa = fwd(op.dp.rn, rs_data_a_i);
    opb = fwd(addr_b, rs_data_b_i);
  end

  assign squash_o = branch_taken_o;
  assign stall_o  = op_valid_i && !squash_o && ex_valid_o
                    && (ex.ls.cls == isa_pkg::CLS_LDST) && ex.ls.l
                    && ((uses_rn && op.dp.rn == ex.ls.rd) || (uses_b && addr_b == ex.ls.rd));

  // ********************
  // Operands and ALU
  // ********************
  shift_unit u_shift (
      .rm_i          (opb)
    , .shift_amt_i   (op.dp.op2.sh.amt)
    , .shift_type_i  (op.dp.op2.sh.typ)
    , .imm8_i        (op.dp.op2.imm.imm8)
    , .rotate_i      (op.dp.op2.imm.rotate)
    , .carry_i       (flags_o[datapath_pkg::FLAG_C])
    , .shifted_o     (shifted)
    , .shift_carry_o (shift_carry)
    , .imm_o         (imm)
    , .imm_carry_o   (imm_carry)
  );

  always_comb begin
    case (op.dp.cls)
      isa_pkg::CLS_DP_REG: op2 = shifted;
      isa_pkg::CLS_DP_IMM: op2 = imm;
      default:             op2 = {{(W-12){1'b0}}, op.ls.offset12};
    endcase
  end

  // U bit picks the address direction
  assign alu_op = is_ldst ? (op.ls.u ? isa_pkg::OP_ADD : isa_pkg::OP_SUB) : op.dp.opcode;

  alu u_alu (
      .clk_i         (clk_i)
    , .reset_i       (reset_i)
    , .opcode_i      (alu_op)
    , .a_i           (opa)
    , .b_i           (op2)
    , .shift_carry_i ((op.dp.cls == isa_pkg::CLS_DP_IMM) ? imm_carry : shift_carry)
    , .s_i           (op.dp.s)
    , .cond_i        (op.dp.cond)
    , .update_i      (op_valid_i && !squash_o && !stall_o && is_dp)
    , .result_o      (alu_result)
    , .cond_met_o    (cond_met)
    , .flags_o       (flags_o)
  );

  // Compare ops are 10xx and write no register
  assign write = (is_dp && op.dp.opcode[3:2] != 2'b10) || is_load;
  assign fire  = op_valid_i && !squash_o && !stall_o && cond_met;

  // ********************
  // Result registers
  // ********************
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      ex_valid_o     <= 1'b0;
      branch_taken_o <= 1'b0;
    end else begin
      ex_valid_o     <= fire;
      branch_taken_o <= fire && is_br;
    end
  end

  always_ff @(posedge clk_i) begin
    ex_inst_o       <= op_inst_i;
    ex_result_o     <= alu_result;
    ex_store_data_o <= opb;
    ex_write_o      <= write;
    branch_offset_o <= {{(W-26){op.br.offset24[23]}}, op.br.offset24, 2'b00};
  end

  a_squash_kills: assert property (
    @(posedge clk_i) disable iff (reset_i) squash_o |=> !ex_valid_o
  );

endmodule

`default_nettype wire

// File: logic/alu.sv
`default_nettype none

module alu (
    input  logic clk_i
  , input  logic reset_i
  , input  isa_pkg::alu_op_e opcode_i
  , input  logic [datapath_pkg::WORD_W-1:0] a_i
  , input  logic [datapath_pkg::WORD_W-1:0] b_i
  , input  logic shift_carry_i
  , input  logic s_i
  , input  isa_pkg::cond_e cond_i
  , input  logic update_i
  , output logic [datapath_pkg::WORD_W-1:0] result_o
  , output logic cond_met_o
  , output logic [datapath_pkg::FLAG_W-1:0] flags_o
);

  localparam int W = datapath_pkg::WORD_W;

  logic [W-1:0] x;
  logic [W-1:0] y;
  logic cin;
  logic arith;
  logic [W:0] sum;
  logic n;
  logic z;
  logic c;
  logic v;
  logic [datapath_pkg::FLAG_W-1:0] flags_next;

  assign n = flags_o[datapath_pkg::FLAG_N];
  assign z = flags_o[datapath_pkg::FLAG_Z];
  assign c = flags_o[datapath_pkg::FLAG_C];
  assign v = flags_o[datapath_pkg::FLAG_V];

  // ********************
  // Adder operand setup
  // ********************
  always_comb begin
    x     = a_i;
    y     = b_i;
    cin   = 1'b0;
    arith = 1'b1;
    case (opcode_i)
      isa_pkg::OP_SUB, isa_pkg::OP_CMP: begin
        y   = ~b_i;
        cin = 1'b1;
      end
      isa_pkg::OP_RSB: begin
        x   = b_i;
        y   = ~a_i;
        cin = 1'b1;
      end
      isa_pkg::OP_ADD, isa_pkg::OP_CMN: cin = 1'b0;
      isa_pkg::OP_ADC: cin = c;
      isa_pkg::OP_SBC: begin
        y   = ~b_i;
        cin = c;
      end
      isa_pkg::OP_RSC: begin
        x   = b_i;
        y   = ~a_i;
        cin = c;
      end
      default: arith = 1'b0;
    endcase
  end

  assign sum = {1'b0, x} + {1'b0, y} + {{W{1'b0}}, cin};

  always_comb begin
    case (opcode_i)
      isa_pkg::OP_AND, isa_pkg::OP_TST: result_o = a_i & b_i;
      isa_pkg::OP_EOR, isa_pkg::OP_TEQ: result_o = a_i ^ b_i;
      isa_pkg::OP_ORR: result_o = a_i | b_i;
      isa_pkg::OP_MOV: result_o = b_i;
      isa_pkg::OP_BIC: result_o = a_i & ~b_i;
      isa_pkg::OP_MVN: result_o = ~b_i;
      default:         result_o = sum[W-1:0];
    endcase
  end

  // Logical ops take C from the shifter and keep V
  always_comb begin
    flags_next[datapath_pkg::FLAG_N] = result_o[W-1];
    flags_next[datapath_pkg::FLAG_Z] = (result_o == '0);
    flags_next[datapath_pkg::FLAG_C] = arith ? sum[W] : shift_carry_i;
    flags_next[datapath_pkg::FLAG_V] = arith ? ((x[W-1] == y[W-1]) && (sum[W-1] != x[W-1])) : v;
  end

  // ********************
  // Condition check
  // ********************
  always_comb begin
    case (cond_i)
      isa_pkg::COND_EQ: cond_met_o = z;
      isa_pkg::COND_NE: cond_met_o = !z;
      isa_pkg::COND_CS: cond_met_o = c;
      isa_pkg::COND_CC: cond_met_o = !c;
      isa_pkg::COND_MI: cond_met_o = n;
      isa_pkg::COND_PL: cond_met_o = !n;
      isa_pkg::COND_VS: cond_met_o = v;
      isa_pkg::COND_VC: cond_met_o = !v;
      isa_pkg::COND_HI: cond_met_o = c && !z;
      isa_pkg::COND_LS: cond_met_o = !c || z;
      isa_pkg::COND_GE: cond_met_o = (n == v);
      isa_pkg::COND_LT: cond_met_o = (n != v);
      isa_pkg::COND_GT: cond_met_o = !z && (n == v);
      isa_pkg::COND_LE: cond_met_o = z || (n != v);
      isa_pkg::COND_AL: cond_met_o = 1'b1;
      // 1111 is never taken
      default:          cond_met_o = 1'b0;
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      flags_o <= '0;
    end else if (update_i && s_i && cond_met_o) begin
      flags_o <= flags_next;
    end
  end

endmodule

`default_nettype wire

// File: logic/shift_unit.sv
`default_nettype none

module shift_unit (
    input  logic [datapath_pkg::WORD_W-1:0] rm_i
  , input  logic [4:0] shift_amt_i
  , input  isa_pkg::shift_e shift_type_i
  , input  logic [7:0] imm8_i
  , input  logic [3:0] rotate_i
  , input  logic carry_i
  , output logic [datapath_pkg::WORD_W-1:0] shifted_o
  , output logic shift_carry_o
  , output logic [datapath_pkg::WORD_W-1:0] imm_o
  , output logic imm_carry_o
);

  localparam int W = datapath_pkg::WORD_W;

  // One extra bit catches the last bit shifted out
  logic [W:0] left_ext;
  logic [W:0] right_ext;
  logic [W:0] arith_ext;
  logic [2*W-1:0] ror_ext;
  logic [2*W-1:0] imm_ext;

  assign left_ext  = {1'b0, rm_i} << shift_amt_i;
  assign right_ext = {rm_i, 1'b0} >> shift_amt_i;
  assign arith_ext = $signed({rm_i, 1'b0}) >>> shift_amt_i;
  assign ror_ext   = {rm_i, rm_i} >> shift_amt_i;

  always_comb begin
    shifted_o     = rm_i;
    shift_carry_o = carry_i;
    if (shift_amt_i != 5'd0) begin
      case (shift_type_i)
        isa_pkg::SH_LSL: {shift_carry_o, shifted_o} = left_ext;
        isa_pkg::SH_LSR: {shifted_o, shift_carry_o} = right_ext;
        isa_pkg::SH_ASR: {shifted_o, shift_carry_o} = arith_ext;
        default: begin
          shifted_o     = ror_ext[W-1:0];
          shift_carry_o = ror_ext[W-1];
        end
      endcase
    end
  end

  // Immediate rotates right by twice the rotate field
  assign imm_ext     = {2{{(W-8){1'b0}}, imm8_i}} >> {rotate_i, 1'b0};
  assign imm_o       = imm_ext[W-1:0];
  assign imm_carry_o = (rotate_i == 4'd0) ? carry_i : imm_ext[W-1];

endmodule

`default_nettype wire

// File: logic/operand_stage.sv
`default_nettype none

module operand_stage (
    input  logic clk_i
  , input  logic reset_i
  , input  logic [datapath_pkg::WORD_W-1:0] instr_i
  , input  logic instr_valid_i
  , input  logic hold_i
  , input  logic squash_i
  , input  logic wb_en_i
  , input  logic [datapath_pkg::REG_AW-1:0] wb_addr_i
  , input  logic [datapath_pkg::WORD_W-1:0] wb_data_i
  , output logic [datapath_pkg::WORD_W-1:0] op_inst_o
  , output logic op_valid_o
  , output logic [datapath_pkg::WORD_W-1:0] rs_data_a_o
  , output logic [datapath_pkg::WORD_W-1:0] rs_data_b_o
);

  logic [datapath_pkg::WORD_W-1:0] regs [datapath_pkg::NUM_REGS];
  isa_pkg::inst_u op;
  logic is_store;
  logic [datapath_pkg::REG_AW-1:0] addr_b;

  // ********************
  // Instruction register
  // ********************

  // Squash takes priority; execute drops the word already held here
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      op_valid_o <= 1'b0;
    end else if (squash_i || !hold_i) begin
      op_valid_o <= instr_valid_i;
    end
  end

  always_ff @(posedge clk_i) begin
    if (squash_i || !hold_i) begin
      op_inst_o <= instr_i;
    end
  end

  // ********************
  // Register file
  // ********************
  always_ff @(posedge clk_i) begin
    if (wb_en_i) begin
      regs[wb_addr_i] <= wb_data_i;
    end
  end

  assign op = op_inst_o;
  assign is_store = (op.ls.cls == isa_pkg::CLS_LDST) && !op.ls.l;

  // Stores read their data register on the second port
  assign addr_b = is_store ? op.ls.rd : op.dp.op2.sh.rm;

  assign rs_data_a_o = regs[op.dp.rn];
  assign rs_data_b_o = regs[addr_b];

  // Stall and branch squash come from execute and must not overlap
  a_no_hold_on_squash: assert property (
    @(posedge clk_i) disable iff (reset_i) !(squash_i && hold_i)
  );

endmodule

`default_nettype wire

// File: logic/isa_pkg.sv
`default_nettype none

package isa_pkg;

  // Instruction class, bits 27:25
  typedef enum logic [2:0] {
    CLS_DP_REG = 3'b000,
    CLS_DP_IMM = 3'b001,
    CLS_LDST   = 3'b010,
    CLS_BRANCH = 3'b101
  } class_e;

  // Data processing opcode, bits 24:21
  typedef enum logic [3:0] {
    OP_AND, OP_EOR, OP_SUB, OP_RSB, OP_ADD, OP_ADC, OP_SBC, OP_RSC,
    OP_TST, OP_TEQ, OP_CMP, OP_CMN, OP_ORR, OP_MOV, OP_BIC, OP_MVN
  } alu_op_e;

  // Condition field, bits 31:28
  typedef enum logic [3:0] {
    COND_EQ, COND_NE, COND_CS, COND_CC, COND_MI, COND_PL, COND_VS, COND_VC,
    COND_HI, COND_LS, COND_GE, COND_LT, COND_GT, COND_LE, COND_AL
  } cond_e;

  typedef enum logic [1:0] {
    SH_LSL, SH_LSR, SH_ASR, SH_ROR
  } shift_e;

  // ********************
  // Instruction word views
  // ********************

  // Second operand of data processing, register or immediate form
  typedef struct packed {
    logic [4:0] amt;
    shift_e     typ;
    logic       reg_shift;
    logic [3:0] rm;
  } op2_shift_t;

  typedef struct packed {
    logic [3:0] rotate;
    logic [7:0] imm8;
  } op2_imm_t;

  typedef union packed {
    op2_shift_t sh;
    op2_imm_t   imm;
  } op2_u;

  typedef struct packed {
    cond_e      cond;
    class_e     cls;
    alu_op_e    opcode;
    logic       s;
    logic [3:0] rn;
    logic [3:0] rd;
    op2_u       op2;
  } dp_t;

  typedef struct packed {
    cond_e       cond;
    class_e      cls;
    logic        p;
    logic        u;
    logic        b;
    logic        w;
    logic        l;
    logic [3:0]  rn;
    logic [3:0]  rd;
    logic [11:0] offset12;
  } ls_t;

  typedef struct packed {
    cond_e       cond;
    class_e      cls;
    logic        link;
    logic [23:0] offset24;
  } br_t;

  typedef union packed {
    dp_t dp;
    ls_t ls;
    br_t br;
  } inst_u;

endpackage

`default_nettype wire

// File: logic/datapath_pkg.sv
`default_nettype none

package datapath_pkg;

  // ********************
  // Word and register file layout
  // ********************
  localparam int WORD_W = 32;
  localparam int REG_AW = 4;
  localparam int NUM_REGS = 1 << REG_AW;

  // ********************
  // Status flag word
  // ********************
  localparam int FLAG_W = 4;

  // Bit positions inside the flag word
  localparam int FLAG_N = 3;
  localparam int FLAG_Z = 2;
  localparam int FLAG_C = 1;
  localparam int FLAG_V = 0;

endpackage

`default_nettype wire
